/* segre_pkg.sv */
package segre_pkg;

    // core word and cache line widths
    localparam int WORD_SIZE        = 32;
    localparam int DCACHE_LANE_SIZE = 128;
    localparam int LANE_BYTES       = DCACHE_LANE_SIZE / 8;

    // access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_data_type_e;

    // one request from the core
    typedef struct packed {
        logic [WORD_SIZE-1:0] addr;
        logic                 we;
        memop_data_type_e     size;
        logic [WORD_SIZE-1:0] data;
    } core_req_t;

    // controller to main memory, read and write ports are independent
    typedef struct packed {
        logic                        rd;
        logic [WORD_SIZE-1:0]        rd_addr;
        logic                        wr;
        logic [WORD_SIZE-1:0]        wr_addr;
        logic [DCACHE_LANE_SIZE-1:0] wr_data;
    } mem_cmd_t;

endpackage

/* main_memory.sv */
`timescale 1ns/1ps

module main_memory #(
    parameter int          MEM_BYTES   = 65536,
    parameter int          MEM_LATENCY = 10,
    parameter logic [31:0] DATA_REGION = 32'hA000
) (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  segre_pkg::mem_cmd_t                    cmd_i,
    output logic                                   data_rdy_o,
    output logic [segre_pkg::DCACHE_LANE_SIZE-1:0] data_o
);

    import segre_pkg::*;

    localparam int AW    = $clog2(MEM_BYTES);
    localparam int OFF_W = $clog2(LANE_BYTES);
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    logic [7:0]                  mem [MEM_BYTES];
    logic [DCACHE_LANE_SIZE-1:0] rd_line;
    logic [CNT_W-1:0]            lat_cnt;
    logic [AW-1:0]               rd_base;
    logic [AW-1:0]               wr_base;

    assign rd_base = cmd_i.rd_addr[AW-1:0];
    assign wr_base = cmd_i.wr_addr[AW-1:0];

    // twenty words at DATA_REGION, blocks of five alternating fafafafa / 5a5a5a5a
    initial begin
        logic [WORD_SIZE-1:0] word;
        int                   idx;
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
        for (int w = 0; w < 20; w++) begin
            word = ((w / 5) % 2 == 0) ? 32'hfafa_fafa : 32'h5a5a_5a5a;
            for (int b = 0; b < 4; b++) begin
                idx      = int'(DATA_REGION) + 4 * w + b;
                mem[idx] = word[8*b +: 8];
            end
        end
    end

    // little-endian line access
    // the read sees the contents from before a same-edge write
    always @(posedge clk_i) begin
        if (cmd_i.rd) begin
            for (int b = 0; b < LANE_BYTES; b++) begin
                rd_line[8*b +: 8] <= mem[rd_base + AW'(b)];
            end
        end
        if (cmd_i.wr) begin
            for (int b = 0; b < LANE_BYTES; b++) begin
                mem[wr_base + AW'(b)] <= cmd_i.wr_data[8*b +: 8];
            end
        end
    end

    // latency counter, ready goes high MEM_LATENCY cycles after the strobe cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lat_cnt    <= '0;
            data_rdy_o <= 1'b0;
        end else begin
            data_rdy_o <= (lat_cnt == CNT_W'(1));
            if (cmd_i.rd) begin
                lat_cnt <= CNT_W'(MEM_LATENCY - 1);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (lat_cnt == CNT_W'(1)) begin
            data_o <= rd_line;
        end
    end

    a_rd_addr_ok: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_i.rd |-> (cmd_i.rd_addr[OFF_W-1:0] == '0) && (cmd_i.rd_addr < 32'(MEM_BYTES)));

    a_wr_addr_ok: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_i.wr |-> (cmd_i.wr_addr[OFF_W-1:0] == '0) && (cmd_i.wr_addr < 32'(MEM_BYTES)));

    // one outstanding read at a time
    a_no_rd_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
        cmd_i.rd |-> (lat_cnt == '0));

endmodule

/* dcache_tags.sv */
`timescale 1ns/1ps

module dcache_tags #(
    parameter int DCACHE_LINES = 4
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic [segre_pkg::WORD_SIZE-1:0] addr_i,
    input  logic                            set_dirty_i,
    input  logic                            fill_i,
    output logic                            hit_o,
    output logic                            victim_dirty_o,
    output logic [segre_pkg::WORD_SIZE-1:0] victim_addr_o
);

    import segre_pkg::*;

    localparam int OFF_W = $clog2(LANE_BYTES);
    localparam int IDX_W = $clog2(DCACHE_LINES);
    localparam int TAG_W = WORD_SIZE - IDX_W - OFF_W;

    logic [DCACHE_LINES-1:0] valid_q;
    logic [DCACHE_LINES-1:0] dirty_q;
    logic [TAG_W-1:0]        tag_q [DCACHE_LINES];
    logic [IDX_W-1:0]        idx;
    logic [TAG_W-1:0]        tag;

    // address split: tag | index | line offset
    assign idx = addr_i[OFF_W +: IDX_W];
    assign tag = addr_i[WORD_SIZE-1 -: TAG_W];

    assign hit_o          = valid_q[idx] && (tag_q[idx] == tag);
    assign victim_dirty_o = valid_q[idx] && dirty_q[idx];

    // line address of whatever currently sits in this index
    assign victim_addr_o = {tag_q[idx], idx, {OFF_W{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_i) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end
            if (set_dirty_i) begin
                dirty_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[idx] <= tag;
        end
    end

    // the controller holds the address, so a refilled line must hit next cycle
    a_fill_then_hit: assert property (@(posedge clk_i) disable iff (reset_i)
        fill_i |=> hit_o);

    // stores only ever land on a resident line
    a_dirty_on_hit: assert property (@(posedge clk_i) disable iff (reset_i)
        set_dirty_i |-> hit_o);

endmodule

/* dcache_data.sv */
`timescale 1ns/1ps

module dcache_data #(
    parameter int DCACHE_LINES = 4
) (
    input  logic                                   clk_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]        addr_i,
    input  segre_pkg::memop_data_type_e            size_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]        wdata_i,
    input  logic                                   store_i,
    input  logic                                   fill_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] fill_line_i,
    output logic [segre_pkg::DCACHE_LANE_SIZE-1:0] line_o,
    output logic [segre_pkg::WORD_SIZE-1:0]        rdata_o
);

    import segre_pkg::*;

    localparam int OFF_W = $clog2(LANE_BYTES);
    localparam int IDX_W = $clog2(DCACHE_LINES);
    localparam int WORDS = DCACHE_LANE_SIZE / WORD_SIZE;

    logic [DCACHE_LANE_SIZE-1:0] lines_q [DCACHE_LINES];
    logic [IDX_W-1:0]            idx;
    logic [OFF_W-3:0]            word_sel;
    logic [1:0]                  byte_sel;
    logic [WORD_SIZE-1:0]        word;
    logic [WORD_SIZE-1:0]        shifted;
    logic [3:0]                  word_be;
    logic [WORD_SIZE-1:0]        store_word;
    logic [LANE_BYTES-1:0]       lane_en;
    logic [DCACHE_LANE_SIZE-1:0] lane_data;
    logic [DCACHE_LANE_SIZE-1:0] merged;

    assign idx      = addr_i[OFF_W +: IDX_W];
    assign word_sel = addr_i[OFF_W-1:2];
    assign byte_sel = addr_i[1:0];
    assign line_o   = lines_q[idx];

    // load path, always zero-extended
    assign word    = line_o[word_sel*WORD_SIZE +: WORD_SIZE];
    assign shifted = word >> {byte_sel, 3'b000};

    always_comb begin
        case (size_i)
            BYTE:    rdata_o = {24'h0, shifted[7:0]};
            HALF:    rdata_o = {16'h0, shifted[15:0]};
            default: rdata_o = word;
        endcase
    end

    // store data replicated so every candidate lane sees the right bytes
    always_comb begin
        case (size_i)
            BYTE: begin
                word_be    = 4'b0001 << byte_sel;
                store_word = {4{wdata_i[7:0]}};
            end
            HALF: begin
                word_be    = 4'b0011 << byte_sel;
                store_word = {2{wdata_i[15:0]}};
            end
            default: begin
                word_be    = 4'b1111;
                store_word = wdata_i;
            end
        endcase
    end

    // refill replaces every lane, a store only the lanes it addresses
    assign lane_en   = fill_i ? '1 : (LANE_BYTES'(word_be) << {word_sel, 2'b00});
    assign lane_data = fill_i ? fill_line_i : {WORDS{store_word}};

    always_comb begin
        for (int b = 0; b < LANE_BYTES; b++) begin
            merged[8*b +: 8] = lane_en[b] ? lane_data[8*b +: 8] : line_o[8*b +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (store_i || fill_i) begin
            lines_q[idx] <= merged;
        end
    end

    a_store_aligned: assert property (@(posedge clk_i)
        store_i |-> (size_i == BYTE) ||
                    (size_i == HALF && !addr_i[0]) ||
                    (size_i == WORD && addr_i[1:0] == 2'b00));

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic                                   req_valid_i,
    input  segre_pkg::core_req_t                   req_i,
    input  logic                                   hit_i,
    input  logic                                   victim_dirty_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]        victim_addr_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] victim_line_i,
    input  logic                                   data_rdy_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]        load_data_i,
    output segre_pkg::mem_cmd_t                    cmd_o,
    output logic                                   store_o,
    output logic                                   set_dirty_o,
    output logic                                   fill_o,
    output segre_pkg::core_req_t                   req_o,
    output logic                                   busy_o,
    output logic                                   done_o,
    output logic [segre_pkg::WORD_SIZE-1:0]        rdata_o
);

    import segre_pkg::*;

    localparam int OFF_W = $clog2(LANE_BYTES);

    typedef enum logic [2:0] {
        IDLE,
        MISS,
        WAIT,
        REPLAY,
        DONE
    } state_e;

    state_e               state_q;
    state_e               state_d;
    core_req_t            req_q;
    logic [WORD_SIZE-1:0] rdata_q;
    logic                 accept;
    logic                 access;

    assign accept = (state_q == IDLE) && req_valid_i;

    // in IDLE the arrays look up the incoming request directly
    assign req_o = (state_q == IDLE) ? req_i : req_q;

    // a hit on arrival, or the replay after a refill
    assign access      = (accept && hit_i) || (state_q == REPLAY);
    assign store_o     = access && req_o.we;
    assign set_dirty_o = store_o;
    assign fill_o      = (state_q == WAIT) && data_rdy_i;

    assign busy_o  = (state_q != IDLE);
    assign done_o  = (state_q == DONE);
    assign rdata_o = rdata_q;

    // refill read and writeback go out together, victim info is indexed by req_q
    always_comb begin
        cmd_o = '0;
        if (state_q == MISS) begin
            cmd_o.rd      = 1'b1;
            cmd_o.rd_addr = {req_q.addr[WORD_SIZE-1:OFF_W], {OFF_W{1'b0}}};
            cmd_o.wr      = victim_dirty_i;
            cmd_o.wr_addr = victim_addr_i;
            cmd_o.wr_data = victim_line_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = hit_i ? DONE : MISS;
                end
            end
            MISS: begin
                state_d = WAIT;
            end
            WAIT: begin
                if (data_rdy_i) begin
                    state_d = REPLAY;
                end
            end
            REPLAY: begin
                state_d = DONE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // stores answer with zero
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (access) begin
            rdata_q <= req_o.we ? '0 : load_data_i;
        end
    end

    a_no_req_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i |-> !busy_o);

    // refill must have made the line resident before the replay
    a_replay_hits: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == REPLAY) |-> hit_i);

endmodule

/* segre_mem_subsys.sv */
`timescale 1ns/1ps

module segre_mem_subsys #(
    parameter int          MEM_BYTES    = 65536,
    parameter int          MEM_LATENCY  = 10,
    parameter logic [31:0] DATA_REGION  = 32'hA000,
    parameter int          DCACHE_LINES = 4
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            req_valid_i,
    input  segre_pkg::core_req_t            req_i,
    output logic                            busy_o,
    output logic                            done_o,
    output logic [segre_pkg::WORD_SIZE-1:0] rdata_o
);

    import segre_pkg::*;

    mem_cmd_t                    cmd;
    core_req_t                   req;
    logic                        hit;
    logic                        victim_dirty;
    logic [WORD_SIZE-1:0]        victim_addr;
    logic [DCACHE_LANE_SIZE-1:0] victim_line;
    logic                        data_rdy;
    logic [DCACHE_LANE_SIZE-1:0] mem_line;
    logic [WORD_SIZE-1:0]        load_data;
    logic                        store;
    logic                        set_dirty;
    logic                        fill;

    dcache_ctrl dcache_ctrl_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_addr_i  (victim_addr),
        .victim_line_i  (victim_line),
        .data_rdy_i     (data_rdy),
        .load_data_i    (load_data),
        .cmd_o          (cmd),
        .store_o        (store),
        .set_dirty_o    (set_dirty),
        .fill_o         (fill),
        .req_o          (req),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .rdata_o        (rdata_o)
    );

    dcache_tags #(
        .DCACHE_LINES (DCACHE_LINES)
    ) dcache_tags_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .addr_i         (req.addr),
        .set_dirty_i    (set_dirty),
        .fill_i         (fill),
        .hit_o          (hit),
        .victim_dirty_o (victim_dirty),
        .victim_addr_o  (victim_addr)
    );

    // refill line comes straight from the memory output
    dcache_data #(
        .DCACHE_LINES (DCACHE_LINES)
    ) dcache_data_inst (
        .clk_i       (clk_i),
        .addr_i      (req.addr),
        .size_i      (req.size),
        .wdata_i     (req.data),
        .store_i     (store),
        .fill_i      (fill),
        .fill_line_i (mem_line),
        .line_o      (victim_line),
        .rdata_o     (load_data)
    );

    main_memory #(
        .MEM_BYTES   (MEM_BYTES),
        .MEM_LATENCY (MEM_LATENCY),
        .DATA_REGION (DATA_REGION)
    ) main_memory_inst (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .cmd_i      (cmd),
        .data_rdy_o (data_rdy),
        .data_o     (mem_line)
    );

endmodule

/* tb_mem_tasks.svh */
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic void model_init();
    logic [31:0] word;
    for (int i = 0; i < MEM_BYTES; i++) begin
        model_mem[i] = 8'h00;
    end
    // words 0-4 and 10-14 hold fafafafa and the other ten hold 5a5a5a5a
    for (int w = 0; w < 20; w++) begin
        word = (w < 5 || (w >= 10 && w < 15)) ? 32'hfafa_fafa : 32'h5a5a_5a5a;
        for (int b = 0; b < 4; b++) begin
            model_mem[int'(DATA_REGION) + 4 * w + b] = word[8*b +: 8];
        end
    end
endfunction

function automatic int size_bytes(input memop_data_type_e size);
    case (size)
        BYTE:    return 1;
        HALF:    return 2;
        default: return 4;
    endcase
endfunction

// loads come back zero-extended
function automatic logic [31:0] model_read(input logic [31:0] addr, input memop_data_type_e size);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < size_bytes(size); b++) begin
        value[8*b +: 8] = model_mem[int'(addr) + b];
    end
    return value;
endfunction

function automatic void model_write(input logic [31:0] addr, input memop_data_type_e size,
                                    input logic [31:0] data);
    for (int b = 0; b < size_bytes(size); b++) begin
        model_mem[int'(addr) + b] = data[8*b +: 8];
    end
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "check failed in %s", name);
    end
endtask

// cycles counts edges from the request edge to the done cycle
task automatic run_access(input string name, input logic we, input memop_data_type_e size,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output int cycles);
    core_req_t req;
    req.addr = addr;
    req.we   = we;
    req.size = size;
    req.data = wdata;
    @(posedge clk_i);
    req_i       <= req;
    req_valid_i <= 1'b1;
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    cycles = 1;
    @(negedge clk_i);
    check_value({name, " busy"}, 32'd1, 32'(busy_o));
    while (!done_o) begin
        @(negedge clk_i);
        cycles++;
    end
    rdata = rdata_o;
    // done lasts one cycle while the load value stays
    @(negedge clk_i);
    check_value({name, " done pulse"}, 32'd0, 32'(done_o));
    check_value({name, " busy release"}, 32'd0, 32'(busy_o));
    check_value({name, " rdata hold"}, rdata, rdata_o);
endtask

task automatic store_access(input string name, input memop_data_type_e size,
                            input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    int          cycles;
    run_access(name, 1'b1, size, addr, data, rdata, cycles);
    check_value(name, 32'd0, rdata);
    model_write(addr, size, data);
endtask

task automatic load_access(input string name, input memop_data_type_e size,
                           input logic [31:0] addr, output int cycles);
    logic [31:0] expected;
    logic [31:0] rdata;
    expected = model_read(addr, size);
    run_access(name, 1'b0, size, addr, 32'd0, rdata, cycles);
    check_value(name, expected, rdata);
endtask

task automatic test_reset_and_hit();
    int cycles;
    @(negedge clk_i);
    check_value("reset busy", 32'd0, 32'(busy_o));
    check_value("reset done", 32'd0, 32'(done_o));
    load_access("first load", WORD, DATA_REGION, cycles);
    check_value("first load value", 32'hfafa_fafa, rdata_o);
    check_value("first load latency", MEM_LATENCY + 3, cycles);
    load_access("repeat load", WORD, DATA_REGION, cycles);
    check_value("repeat load value", 32'hfafa_fafa, rdata_o);
    check_value("hit latency", 32'd1, cycles);
endtask

task automatic test_region_pattern();
    int cycles;
    load_access("second block load", WORD, DATA_REGION + 20, cycles);
    check_value("second block value", 32'h5a5a_5a5a, rdata_o);
    check_value("second block latency", MEM_LATENCY + 3, cycles);
    load_access("below region load", WORD, DATA_REGION - 4, cycles);
    check_value("below region value", 32'd0, rdata_o);
    check_value("below region latency", MEM_LATENCY + 3, cycles);
endtask

task automatic test_sub_word_access();
    logic [31:0] addr;
    int          cycles;
    addr = DATA_REGION + 32'h30;
    store_access("word store", WORD, addr, 32'h1122_3344);
    store_access("byte store", BYTE, addr + 1, 32'h0000_00ab);
    store_access("half store", HALF, addr + 2, 32'h0000_beef);
    load_access("word load", WORD, addr, cycles);
    load_access("low half load", HALF, addr, cycles);
    load_access("high half load", HALF, addr + 2, cycles);
    for (int b = 0; b < 4; b++) begin
        load_access($sformatf("byte load %0d", b), BYTE, addr + b, cycles);
    end
endtask

// stride of four lines lands on the same index
task automatic test_dirty_writeback();
    logic [31:0] addr;
    int          cycles;
    addr = DATA_REGION + 32'h8;
    store_access("dirty store", WORD, addr, 32'h1234_5678);
    load_access("evict load", WORD, addr + 32'd64, cycles);
    check_value("dirty miss latency", MEM_LATENCY + 3, cycles);
    load_access("second evict load", WORD, addr + 32'd128, cycles);
    load_access("reload stored", WORD, addr, cycles);
    check_value("reload latency", MEM_LATENCY + 3, cycles);
endtask

task automatic test_random_traffic();
    logic [31:0]      addr;
    logic [31:0]      data;
    logic             we;
    memop_data_type_e size;
    int               cycles;
    string            name;
    for (int i = 0; i < 200; i++) begin
        rng_state = xorshift32(rng_state);
        addr      = DATA_REGION - 32'd2048 + (rng_state & 32'h0000_0fff);
        rng_state = xorshift32(rng_state);
        size      = memop_data_type_e'(2'(rng_state % 3));
        we        = rng_state[8];
        rng_state = xorshift32(rng_state);
        data      = rng_state;
        if (size == WORD) begin
            addr[1:0] = 2'b00;
        end else if (size == HALF) begin
            addr[0] = 1'b0;
        end
        name = $sformatf("random access %0d", i);
        if (we) begin
            store_access(name, size, addr, data);
        end else begin
            load_access(name, size, addr, cycles);
        end
    end
endtask

`endif

/* tb_segre_mem_subsys.sv */
`timescale 1ns/1ps

module tb_segre_mem_subsys;

    import segre_pkg::*;

    localparam int          MEM_BYTES    = 65536;
    localparam int          MEM_LATENCY  = 10;
    localparam logic [31:0] DATA_REGION  = 32'hA000;
    localparam int          DCACHE_LINES = 4;
    localparam int          RESET_CYCLES = 8;
    // 300 requests of at most 16 cycles each
    localparam int          MAX_CYCLES   = 300 * 16 + RESET_CYCLES;

    logic                 clk_i;
    logic                 reset_i;
    logic                 req_valid_i;
    core_req_t            req_i;
    logic                 busy_o;
    logic                 done_o;
    logic [WORD_SIZE-1:0] rdata_o;

    // reference copy of main memory, byte addressed, little-endian
    logic [7:0]  model_mem [MEM_BYTES];
    logic [31:0] rng_state;
    int          cycle_count = 0;

    `include "tb_mem_tasks.svh"

    segre_mem_subsys #(
        .MEM_BYTES    (MEM_BYTES),
        .MEM_LATENCY  (MEM_LATENCY),
        .DATA_REGION  (DATA_REGION),
        .DCACHE_LINES (DCACHE_LINES)
    ) segre_mem_subsys_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #10 clk_i = ~clk_i;

    // watchdog
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: test sequence still running after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rng_state   = 32'h2986_f9d8;
        model_init();

        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;

        test_reset_and_hit();
        test_region_pattern();
        test_sub_word_access();
        test_dirty_writeback();
        test_random_traffic();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* segre_mem_subsys.f */
+incdir+.
segre_pkg.sv
main_memory.sv
dcache_tags.sv
dcache_data.sv
dcache_ctrl.sv
segre_mem_subsys.sv
tb_segre_mem_subsys.sv

/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_segre_mem_subsys
FILELIST   := segre_mem_subsys.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TEST FAIL
PASS_MSG   := TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
